// File: Makefile
TOP := tb_dcache
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^SIMULATION PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
logic/dcache_pkg.sv
logic/dcache_ctrl.sv
logic/dcache_directory.sv
logic/dcache_data_array.sv
logic/dcache_top.sv
testbench/dcache_checker.sv
testbench/tb_burst_mem.sv
testbench/tb_dcache.sv

// File: logic/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req,
    input  cpu_req_t req_info,
    output logic     addr_ok,
    output logic     data_ok,
    output word_t    rdata,
    output mem_out_t mem_o,
    input  mem_in_t  mem_i,
    output addr_t    cur_addr,
    input  logic     hit,
    input  logic     hit_way,
    input  logic     victim_way,
    input  logic     victim_dirty,
    input  addr_t    victim_line_addr,
    input  word_t    hit_word,
    input  word_t    victim_word,
    output logic     fill_tag_we,
    output logic     touch,
    output logic     mark_dirty,
    output logic     word_we,
    output logic     we_way,
    output beat_t    we_beat,
    output word_t    we_data,
    output strb_t    we_strb,
    output beat_t    rd_beat
);

    localparam beat_t LAST_BEAT = beat_t'(LINE_WORDS - 1);

    cache_state_e state;
    cache_state_e state_next;
    cpu_req_t     req_q;
    beat_t        beat_q;
    logic         accept;
    logic         lookup_hit;

    assign addr_ok    = (state == ST_IDLE);
    assign accept     = req && addr_ok;
    assign lookup_hit = (state == ST_LOOKUP) && hit;

    // held request
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_q <= req_info;
        end
    end

    assign cur_addr = req_q.addr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:      if (accept) state_next = ST_LOOKUP;
            ST_LOOKUP:
            begin
                if (hit)
                    state_next = ST_IDLE;
                else if (victim_dirty)
                    state_next = ST_WB_ADDR;
                else
                    state_next = ST_FILL_ADDR;
            end
            ST_WB_ADDR:   if (mem_i.aw_ready) state_next = ST_WB_DATA;
            ST_WB_DATA:   if (mem_i.w_ready && beat_q == LAST_BEAT) state_next = ST_WB_RESP;
            ST_WB_RESP:   if (mem_i.b_valid) state_next = ST_FILL_ADDR;
            ST_FILL_ADDR: if (mem_i.ar_ready) state_next = ST_FILL_DATA;
            // refilled line hits on the second lookup
            ST_FILL_DATA: if (mem_i.r_valid && mem_i.r_last) state_next = ST_LOOKUP;
            default:      state_next = ST_IDLE;
        endcase
    end

    // beat counter shared by write-back and refill
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            beat_q <= '0;
        end
        else if ((state == ST_WB_ADDR && mem_i.aw_ready) ||
                 (state == ST_FILL_ADDR && mem_i.ar_ready))
        begin
            beat_q <= '0;
        end
        else if ((state == ST_WB_DATA && mem_i.w_ready) ||
                 (state == ST_FILL_DATA && mem_i.r_valid))
        begin
            beat_q <= beat_q + 1'b1;
        end
    end

    assign rd_beat = beat_q;

    // processor side
    assign data_ok = lookup_hit;
    assign rdata   = hit_word;

    // directory updates
    assign touch       = lookup_hit;
    assign mark_dirty  = lookup_hit && req_q.wr;
    assign fill_tag_we = (state == ST_FILL_DATA) && mem_i.r_valid && mem_i.r_last;

    // write source: refill beat or write hit
    always_comb
    begin
        word_we = 1'b0;
        we_way  = hit_way;
        we_beat = word_of(cur_addr);
        we_data = req_q.wdata;
        we_strb = req_q.wstrb;
        if (state == ST_FILL_DATA)
        begin
            word_we = mem_i.r_valid;
            we_way  = victim_way;
            we_beat = beat_q;
            we_data = mem_i.r_data;
            we_strb = '1;
        end
        else if (lookup_hit && req_q.wr)
        begin
            word_we = 1'b1;
        end
    end

    // memory strobes follow the state alone
    always_comb
    begin
        mem_o          = '0;
        mem_o.ar_valid = (state == ST_FILL_ADDR);
        mem_o.ar_addr  = line_base(cur_addr);
        mem_o.r_ready  = (state == ST_FILL_DATA);
        mem_o.aw_valid = (state == ST_WB_ADDR);
        mem_o.aw_addr  = victim_line_addr;
        mem_o.w_valid  = (state == ST_WB_DATA);
        mem_o.w_data   = victim_word;
        mem_o.w_last   = (state == ST_WB_DATA) && (beat_q == LAST_BEAT);
        mem_o.b_ready  = (state == ST_WB_RESP);
    end

endmodule

// File: logic/dcache_data_array.sv
`timescale 1ns/1ps

module dcache_data_array
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 128
)
(
    input  logic  clk,
    input  addr_t cur_addr,
    input  logic  hit_way,
    input  logic  victim_way,
    input  beat_t rd_beat,
    input  logic  word_we,
    input  logic  we_way,
    input  beat_t we_beat,
    input  word_t we_data,
    input  strb_t we_strb,
    output word_t hit_word,
    output word_t victim_word
);

    localparam int IDX_W = $clog2(NUM_SETS);

    // two ways of 8-word lines
    word_t line_q [2][NUM_SETS][LINE_WORDS];

    logic [IDX_W-1:0] idx;

    assign idx = cur_addr[OFFSET_W +: IDX_W];

    // byte lanes written under the strobe
    always_ff @(posedge clk)
    begin
        if (word_we)
        begin
            for (int b = 0; b < WORD_W / 8; b++)
            begin
                if (we_strb[b])
                begin
                    line_q[we_way][idx][we_beat][8*b +: 8] <= we_data[8*b +: 8];
                end
            end
        end
    end

    // addressed word of the hitting way
    assign hit_word = line_q[hit_way][idx][word_of(cur_addr)];

    // write-back source, stepped by the beat counter
    assign victim_word = line_q[victim_way][idx][rd_beat];

endmodule

// File: logic/dcache_directory.sv
`timescale 1ns/1ps

module dcache_directory
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 128
)
(
    input  logic  clk,
    input  logic  rst,
    input  addr_t cur_addr,
    input  logic  fill_tag_we,
    input  logic  touch,
    input  logic  mark_dirty,
    output logic  hit,
    output logic  hit_way,
    output logic  victim_way,
    output logic  victim_dirty,
    output addr_t victim_line_addr
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = 32 - OFFSET_W - IDX_W;

    logic [TAG_W-1:0]               tag_q [2][NUM_SETS];
    logic [1:0][NUM_SETS-1:0]       valid_q;
    logic [1:0][NUM_SETS-1:0]       dirty_q;
    // way used most recently, per set
    logic [NUM_SETS-1:0]            lru_q;

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic [1:0]       way_hit;

    assign idx = cur_addr[OFFSET_W +: IDX_W];
    assign tag = cur_addr[31 -: TAG_W];

    assign way_hit[0] = valid_q[0][idx] && (tag_q[0][idx] == tag);
    assign way_hit[1] = valid_q[1][idx] && (tag_q[1][idx] == tag);
    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];

    // replace the way not used last
    assign victim_way       = ~lru_q[idx];
    assign victim_dirty     = valid_q[victim_way][idx] && dirty_q[victim_way][idx];
    assign victim_line_addr = {tag_q[victim_way][idx], idx, {OFFSET_W{1'b0}}};

    always_ff @(posedge clk)
    begin
        if (fill_tag_we)
        begin
            tag_q[victim_way][idx] <= tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
            dirty_q <= '0;
        end
        else if (fill_tag_we)
        begin
            valid_q[victim_way][idx] <= 1'b1;
            dirty_q[victim_way][idx] <= 1'b0;
        end
        else if (mark_dirty)
        begin
            dirty_q[hit_way][idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lru_q <= '0;
        end
        else if (touch)
        begin
            lru_q[idx] <= hit_way;
        end
    end

endmodule

// File: logic/dcache_pkg.sv
package dcache_pkg;

    // line geometry
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 8;
    localparam int OFFSET_W   = 5;

    typedef logic [WORD_W-1:0]               word_t;
    typedef logic [31:0]                     addr_t;
    typedef logic [WORD_W/8-1:0]             strb_t;
    typedef logic [$clog2(LINE_WORDS)-1:0]   beat_t;

    // controller states, one request in flight
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WB_ADDR,
        ST_WB_DATA,
        ST_WB_RESP,
        ST_FILL_ADDR,
        ST_FILL_DATA
    } cache_state_e;

    // processor request, 69 bits
    typedef struct packed {
        logic  wr;
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
    } cpu_req_t;

    // cache toward memory, valid/ready pairs only
    typedef struct packed {
        logic  ar_valid;
        addr_t ar_addr;
        logic  r_ready;
        logic  aw_valid;
        addr_t aw_addr;
        logic  w_valid;
        word_t w_data;
        logic  w_last;
        logic  b_ready;
    } mem_out_t;

    // memory back toward the cache
    typedef struct packed {
        logic  ar_ready;
        logic  r_valid;
        word_t r_data;
        logic  r_last;
        logic  aw_ready;
        logic  w_ready;
        logic  b_valid;
    } mem_in_t;

    // byte address of the first word of the line
    function automatic addr_t line_base(input addr_t a);
        return {a[31:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

    // word position inside the line
    function automatic beat_t word_of(input addr_t a);
        return a[OFFSET_W-1:2];
    endfunction

endpackage

// File: logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 128
)
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req,
    input  cpu_req_t req_info,
    output logic     addr_ok,
    output logic     data_ok,
    output word_t    rdata,
    output mem_out_t mem_o,
    input  mem_in_t  mem_i
);

    addr_t cur_addr;
    logic  hit;
    logic  hit_way;
    logic  victim_way;
    logic  victim_dirty;
    addr_t victim_line_addr;
    word_t hit_word;
    word_t victim_word;

    // update strobes from the controller
    logic  fill_tag_we;
    logic  touch;
    logic  mark_dirty;
    logic  word_we;
    logic  we_way;
    beat_t we_beat;
    word_t we_data;
    strb_t we_strb;
    beat_t rd_beat;

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .req              (req),
        .req_info         (req_info),
        .addr_ok          (addr_ok),
        .data_ok          (data_ok),
        .rdata            (rdata),
        .mem_o            (mem_o),
        .mem_i            (mem_i),
        .cur_addr         (cur_addr),
        .hit              (hit),
        .hit_way          (hit_way),
        .victim_way       (victim_way),
        .victim_dirty     (victim_dirty),
        .victim_line_addr (victim_line_addr),
        .hit_word         (hit_word),
        .victim_word      (victim_word),
        .fill_tag_we      (fill_tag_we),
        .touch            (touch),
        .mark_dirty       (mark_dirty),
        .word_we          (word_we),
        .we_way           (we_way),
        .we_beat          (we_beat),
        .we_data          (we_data),
        .we_strb          (we_strb),
        .rd_beat          (rd_beat)
    );

    dcache_directory #(
        .NUM_SETS (NUM_SETS)
    ) u_directory (
        .clk              (clk),
        .rst              (rst),
        .cur_addr         (cur_addr),
        .fill_tag_we      (fill_tag_we),
        .touch            (touch),
        .mark_dirty       (mark_dirty),
        .hit              (hit),
        .hit_way          (hit_way),
        .victim_way       (victim_way),
        .victim_dirty     (victim_dirty),
        .victim_line_addr (victim_line_addr)
    );

    dcache_data_array #(
        .NUM_SETS (NUM_SETS)
    ) u_data_array (
        .clk         (clk),
        .cur_addr    (cur_addr),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .rd_beat     (rd_beat),
        .word_we     (word_we),
        .we_way      (we_way),
        .we_beat     (we_beat),
        .we_data     (we_data),
        .we_strb     (we_strb),
        .hit_word    (hit_word),
        .victim_word (victim_word)
    );

endmodule

// File: testbench/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     addr_ok,
    input  logic     data_ok,
    input  mem_out_t mem_o,
    input  mem_in_t  mem_i
);

    int failures = 0;

    // valid and payload hold until the matching ready
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        mem_o.ar_valid && !mem_i.ar_ready |=> mem_o.ar_valid && $stable(mem_o.ar_addr))
        else begin failures++; $error("ar_valid or ar_addr changed before ar_ready"); end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        mem_o.aw_valid && !mem_i.aw_ready |=> mem_o.aw_valid && $stable(mem_o.aw_addr))
        else begin failures++; $error("aw_valid or aw_addr changed before aw_ready"); end

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        mem_o.w_valid && !mem_i.w_ready |=> mem_o.w_valid && $stable(mem_o.w_data))
        else begin failures++; $error("w_valid or w_data changed before w_ready"); end

    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        mem_i.r_valid && !mem_o.r_ready |=> mem_i.r_valid && $stable(mem_i.r_data))
        else begin failures++; $error("r_valid or r_data changed before r_ready"); end

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        mem_i.b_valid && !mem_o.b_ready |=> mem_i.b_valid)
        else begin failures++; $error("b_valid dropped before b_ready"); end

    a_w_last: assert property (@(posedge clk) disable iff (rst)
        mem_o.w_last |-> mem_o.w_valid)
        else begin failures++; $error("w_last without w_valid"); end

    a_ok_excl: assert property (@(posedge clk) disable iff (rst)
        !(data_ok && addr_ok))
        else begin failures++; $error("data_ok and addr_ok high together"); end

endmodule

bind dcache_top dcache_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .addr_ok (addr_ok),
    .data_ok (data_ok),
    .mem_o   (mem_o),
    .mem_i   (mem_i)
);

// File: testbench/tb_burst_mem.sv
`timescale 1ns/1ps

module tb_burst_mem
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  mem_out_t mem_o,
    output mem_in_t  mem_i,
    output int       read_bursts,
    output int       write_bursts
);

    // sparse backing store, untouched words keep their fill pattern
    word_t mem [addr_t];

    addr_t rd_addr;
    addr_t wr_addr;
    beat_t rd_beat;
    beat_t wr_beat;
    logic  rd_busy;
    logic  wr_busy;

    function automatic word_t load(input addr_t a);
        if (mem.exists(a))
        begin
            return mem[a];
        end
        return a ^ 32'h5a5a_0000;
    endfunction

    // ready or valid offered about two cycles in three
    function automatic logic ready_now();
        return ($urandom % 3) != 0;
    endfunction

    always @(posedge clk)
    begin
        if (rst)
        begin
            mem_i        <= '0;
            rd_busy      <= 1'b0;
            wr_busy      <= 1'b0;
            rd_beat      <= '0;
            wr_beat      <= '0;
            read_bursts  <= 0;
            write_bursts <= 0;
        end
        else
        begin
            // read address, one burst at a time
            mem_i.ar_ready <= ready_now() && !rd_busy;
            if (mem_o.ar_valid && mem_i.ar_ready)
            begin
                rd_busy        <= 1'b1;
                rd_addr        <= mem_o.ar_addr;
                rd_beat        <= '0;
                read_bursts    <= read_bursts + 1;
                mem_i.ar_ready <= 1'b0;
            end
            // read data holds until taken
            if (mem_i.r_valid && mem_o.r_ready)
            begin
                mem_i.r_valid <= 1'b0;
                rd_beat       <= rd_beat + 3'd1;
                if (mem_i.r_last)
                begin
                    rd_busy <= 1'b0;
                end
            end
            else if (rd_busy && !mem_i.r_valid && ready_now())
            begin
                mem_i.r_valid <= 1'b1;
                mem_i.r_data  <= load(rd_addr + {27'd0, rd_beat, 2'b00});
                mem_i.r_last  <= (rd_beat == 3'd7);
            end

            // write address and data
            mem_i.aw_ready <= ready_now() && !wr_busy;
            if (mem_o.aw_valid && mem_i.aw_ready)
            begin
                wr_busy        <= 1'b1;
                wr_addr        <= mem_o.aw_addr;
                wr_beat        <= '0;
                write_bursts   <= write_bursts + 1;
                mem_i.aw_ready <= 1'b0;
            end
            mem_i.w_ready <= ready_now() && wr_busy;
            if (mem_o.w_valid && mem_i.w_ready)
            begin
                mem[wr_addr + {27'd0, wr_beat, 2'b00}] = mem_o.w_data;
                wr_beat <= wr_beat + 3'd1;
                if (mem_o.w_last)
                begin
                    wr_busy       <= 1'b0;
                    mem_i.w_ready <= 1'b0;
                    mem_i.b_valid <= 1'b1;
                end
            end
            if (mem_i.b_valid && mem_o.b_ready)
            begin
                mem_i.b_valid <= 1'b0;
            end
        end
    end

endmodule

// File: testbench/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int NUM_SETS = 128;
    localparam int IDX_W    = $clog2(NUM_SETS);
    localparam int LIMIT    = 2000;
    localparam int SEED     = 32'h59df_ddda;

    logic     clk;
    logic     rst;
    logic     req;
    cpu_req_t req_info;
    logic     addr_ok;
    logic     data_ok;
    word_t    rdata;
    mem_out_t mem_o;
    mem_in_t  mem_i;
    int       read_bursts;
    int       write_bursts;

    // reference state: shadow memory plus directory model
    word_t       shadow [addr_t];
    logic [31:0] m_tag [2][NUM_SETS];
    bit          m_valid [2][NUM_SETS];
    bit          m_dirty [2][NUM_SETS];
    bit          m_mru [NUM_SETS];
    int          exp_rd;
    int          exp_wr;

    word_t exp_data_q [$];
    bit    exp_read_q [$];
    word_t exp_word;
    string test_name;
    string stop_reason;
    bit    timed_out;
    int    tests;
    int    checks;
    int    errors;
    int    test_start_errors;

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    dcache_top #(
        .NUM_SETS (NUM_SETS)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_info (req_info),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .mem_o    (mem_o),
        .mem_i    (mem_i)
    );

    tb_burst_mem u_mem (
        .clk          (clk),
        .rst          (rst),
        .mem_o        (mem_o),
        .mem_i        (mem_i),
        .read_bursts  (read_bursts),
        .write_bursts (write_bursts)
    );

    function automatic addr_t compose_addr(input int tag, input int set, input int word);
        return (addr_t'(tag) << (OFFSET_W + IDX_W)) | (addr_t'(set) << OFFSET_W) |
               (addr_t'(word) << 2);
    endfunction

    // expected word after one access, and whether the lookup hits
    function automatic word_t predict_access(input bit wr, input addr_t a, input word_t wdata,
                                              input strb_t wstrb, output bit exp_hit);
        addr_t       wa;
        int          idx;
        int          way;
        logic [31:0] tag;
        word_t       cur;
        wa      = {a[31:2], 2'b00};
        idx     = int'(a[OFFSET_W +: IDX_W]);
        tag     = a >> (OFFSET_W + IDX_W);
        exp_hit = 1'b0;
        way     = 0;
        for (int w = 0; w < 2; w++)
        begin
            if (m_valid[w][idx] && m_tag[w][idx] == tag)
            begin
                exp_hit = 1'b1;
                way     = w;
            end
        end
        if (!exp_hit)
        begin
            // victim is the way not used last
            way = m_mru[idx] ? 0 : 1;
            if (m_valid[way][idx] && m_dirty[way][idx])
            begin
                exp_wr++;
            end
            exp_rd++;
            m_tag[way][idx]   = tag;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
        end
        m_mru[idx] = (way == 1);
        cur = shadow.exists(wa) ? shadow[wa] : (wa ^ 32'h5a5a_0000);
        if (wr)
        begin
            m_dirty[way][idx] = 1'b1;
            for (int b = 0; b < 4; b++)
            begin
                if (wstrb[b])
                begin
                    cur[8*b +: 8] = wdata[8*b +: 8];
                end
            end
            shadow[wa] = cur;
        end
        return cur;
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        checks++;
        if (exp != act)
        begin
            errors++;
            $display("Error: %s %s expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    // one request, held until accepted, then wait for data_ok
    task automatic access(input bit wr, input addr_t a, input word_t wdata, input strb_t wstrb);
        bit    exp_hit;
        word_t exp;
        int    t;
        if (timed_out)
        begin
            return;
        end
        exp = predict_access(wr, a, wdata, wstrb, exp_hit);
        exp_data_q.push_back(exp);
        exp_read_q.push_back(!wr);
        @(negedge clk);
        req      = 1'b1;
        req_info = {wr, a, wdata, wstrb};
        t = 0;
        while (!addr_ok && t < LIMIT)
        begin
            @(negedge clk);
            t++;
        end
        if (!addr_ok)
        begin
            timed_out   = 1'b1;
            stop_reason = "addr_ok never came";
            req         = 1'b0;
            return;
        end
        @(negedge clk);
        req = 1'b0;
        t = 1;
        while (!data_ok && t < LIMIT)
        begin
            @(negedge clk);
            t++;
        end
        if (!data_ok)
        begin
            timed_out   = 1'b1;
            stop_reason = "data_ok never came";
            return;
        end
        if (exp_hit)
        begin
            check_count("hit latency", 1, t);
        end
    endtask

    task automatic read_word(input addr_t a);
        access(1'b0, a, '0, '0);
    endtask

    task automatic write_word(input addr_t a, input word_t wdata, input strb_t wstrb);
        access(1'b1, a, wdata, wstrb);
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = errors;
    endtask

    task automatic finish_test();
        @(negedge clk);
        check_count("read bursts", exp_rd, read_bursts);
        check_count("write bursts", exp_wr, write_bursts);
        tests++;
        if (errors == test_start_errors)
        begin
            $display("test %s: ok", test_name);
        end
        else
        begin
            $display("test %s: %0d errors", test_name, errors - test_start_errors);
        end
    endtask

    // read data compared as each request completes
    always @(negedge clk)
    begin
        if (!rst && data_ok)
        begin
            if (exp_data_q.size() == 0)
            begin
                errors++;
                $display("data_ok came with no request outstanding in %s", test_name);
            end
            else
            begin
                exp_word = exp_data_q.pop_front();
                if (exp_read_q.pop_front())
                begin
                    check_word("read data", exp_word, rdata);
                end
            end
        end
    end

    initial
    begin
        addr_t a;
        int    base;
        void'($urandom(SEED));
        rst      = 1'b1;
        req      = 1'b0;
        req_info = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset");
        check_count("data_ok", 0, int'(data_ok));
        check_count("ar_valid", 0, int'(mem_o.ar_valid));
        check_count("aw_valid", 0, int'(mem_o.aw_valid));
        check_count("w_valid", 0, int'(mem_o.w_valid));
        read_word(compose_addr(1, 3, 0));
        finish_test();

        start_test("read_miss");
        read_word(compose_addr(2, 5, 3));
        base = read_bursts;
        read_word(compose_addr(2, 5, 6));
        check_count("repeat read bursts", base, read_bursts);
        finish_test();

        start_test("byte_merge");
        a = compose_addr(1, 9, 2);
        write_word(a, 32'haabb_ccdd, 4'b0101);
        write_word(a, 32'h1122_3344, 4'b1000);
        read_word(a);
        read_word(compose_addr(1, 9, 3));
        finish_test();

        // A, B and C share set 12
        start_test("lru");
        read_word(compose_addr(1, 12, 0));
        read_word(compose_addr(2, 12, 0));
        read_word(compose_addr(1, 12, 0));
        read_word(compose_addr(3, 12, 0));
        base = read_bursts;
        read_word(compose_addr(1, 12, 0));
        check_count("read of A bursts", base, read_bursts);
        read_word(compose_addr(2, 12, 0));
        check_count("read of B bursts", base + 1, read_bursts);
        finish_test();

        // reading A back refills it from memory after the write-back
        start_test("writeback");
        a = compose_addr(1, 20, 4);
        write_word(a, 32'hdead_beef, 4'b0011);
        read_word(compose_addr(2, 20, 0));
        base = write_bursts;
        read_word(compose_addr(3, 20, 0));
        check_count("dirty victim write bursts", base + 1, write_bursts);
        read_word(a);
        check_count("clean victim write bursts", base + 1, write_bursts);
        finish_test();

        start_test("random");
        for (int i = 0; i < 400; i++)
        begin
            a = compose_addr(int'($urandom % 4), 40 + int'($urandom % 3), int'($urandom % 8));
            if ($urandom % 2 == 1)
            begin
                write_word(a, $urandom, strb_t'($urandom));
            end
            else
            begin
                read_word(a);
            end
        end
        finish_test();

        check_count("assertion failures", 0, dut.u_checker.failures);
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (timed_out)
        begin
            $display("run stopped early in %s: %s", test_name, stop_reason);
        end
        if (errors == 0 && !timed_out)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
